// File: compile.f
+incdir+include
logic/xbar_pkg.sv
logic/addr_decode.sv
logic/xbar_demux.sv
logic/err_target.sv
logic/xbar_mux.sv
logic/xbar_top.sv
verification/xbar_assert.sv
verification/xbar_tb.sv

// File: Makefile
TOP = xbar_tb

all: run

build:
	verilator --binary --assert -Wno-fatal --top-module $(TOP) -f compile.f

run: build
	./obj_dir/V$(TOP)

lint:
	verilator --lint-only -Wall --timing --assert --top-module $(TOP) -f compile.f

clean:
	rm -rf obj_dir

.PHONY: all build run lint clean

// File: verification/xbar_tb.sv
// Directed testbench that drives both crossbar initiators and models both targets
`timescale 1ns/1ns
`include "xbar_consts.svh"

module xbar_tb;

  import xbar_pkg::*;

  localparam int    CLK_PERIOD      = 20;
  localparam int    RESET_CYCLES    = 16;
  localparam int    TEST_LEN_SUM    = 6 + 3 + 8 + 3 + 8;  // Beats per test in run order
  localparam int    WATCHDOG_CYCLES = TEST_LEN_SUM * 40;
  localparam int    ERR_DST         = `XBAR_NUM_TARGET;   // Destination code of the error lane
  localparam data_t RDATA_TAG       = 32'h0000_5a00;      // Target models answer addr + tag

  logic                                     clk_i;
  logic                                     reset_i;
  init_req_t [`XBAR_NUM_INIT-1:0]           init_req_i;
  logic [`XBAR_NUM_INIT-1:0]                init_req_valid_i;
  logic [`XBAR_NUM_INIT-1:0]                init_req_ready_o;
  init_rsp_t [`XBAR_NUM_INIT-1:0]           init_rsp_o;
  logic [`XBAR_NUM_INIT-1:0]                init_rsp_valid_o;
  logic [`XBAR_NUM_INIT-1:0]                init_rsp_ready_i;
  tgt_req_t [`XBAR_NUM_TARGET-1:0]          tgt_req_o;
  logic [`XBAR_NUM_TARGET-1:0]              tgt_req_valid_o;
  logic [`XBAR_NUM_TARGET-1:0]              tgt_req_ready_i = '0;
  tgt_rsp_t [`XBAR_NUM_TARGET-1:0]          tgt_rsp_i       = '0;
  logic [`XBAR_NUM_TARGET-1:0]              tgt_rsp_valid_i = '0;
  logic [`XBAR_NUM_TARGET-1:0]              tgt_rsp_ready_o;
  rule_t [`XBAR_NUM_RULES-1:0]              addr_map_i;
  logic [`XBAR_NUM_INIT-1:0]                en_default_i;
  tgt_idx_t [`XBAR_NUM_INIT-1:0]            default_idx_i;

  // Expected target beats indexed [target * NUM_INIT + initiator]
  tgt_req_t  exp_req [`XBAR_NUM_TARGET*`XBAR_NUM_INIT][$];
  init_rsp_t exp_rsp [`XBAR_NUM_INIT][$];
  tgt_rsp_t  pend [`XBAR_NUM_TARGET][$];          // Responses owed by each target model
  logic      arrival_src [`XBAR_NUM_TARGET][$];   // Source initiator of each target beat
  init_id_t  next_id [`XBAR_NUM_INIT];
  int        rsp_wait [`XBAR_NUM_TARGET] = '{default: 0};
  logic [`XBAR_NUM_TARGET-1:0] rsp_taken = '0;
  logic [`XBAR_NUM_TARGET-1:0] hold_low  = '0;    // Force target ready low

  xbar_top u_xbar_top (
    .clk_i            (clk_i),
    .reset_i          (reset_i),
    .init_req_i       (init_req_i),
    .init_req_valid_i (init_req_valid_i),
    .init_req_ready_o (init_req_ready_o),
    .init_rsp_o       (init_rsp_o),
    .init_rsp_valid_o (init_rsp_valid_o),
    .init_rsp_ready_i (init_rsp_ready_i),
    .tgt_req_o        (tgt_req_o),
    .tgt_req_valid_o  (tgt_req_valid_o),
    .tgt_req_ready_i  (tgt_req_ready_i),
    .tgt_rsp_i        (tgt_rsp_i),
    .tgt_rsp_valid_i  (tgt_rsp_valid_i),
    .tgt_rsp_ready_o  (tgt_rsp_ready_o),
    .addr_map_i       (addr_map_i),
    .en_default_i     (en_default_i),
    .default_idx_i    (default_idx_i)
  );

  bind xbar_top xbar_assert u_xbar_assert (.*);

  initial begin : clock_gen
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  initial begin : watchdog
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    abort_run($sformatf("Timeout, the tests did not finish within %0d cycles", WATCHDOG_CYCLES));
  end

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("Simulation FAILED");
    $fatal(1, "Run stopped at %0t", $time);
  endtask

  task automatic check_tgt_req(input tgt_req_t got, input tgt_req_t exp, input string what);
    if (got !== exp) begin
      abort_run($sformatf("Fail %0t: %s got %h, expected %h", $time, what, got, exp));
    end
  endtask

  task automatic check_init_rsp(input init_rsp_t got, input init_rsp_t exp, input string what);
    if (got !== exp) begin
      abort_run($sformatf("Fail %0t: %s got %h, expected %h", $time, what, got, exp));
    end
  endtask

  function automatic rule_t build_rule(input tgt_idx_t idx, input addr_t lo, input addr_t hi);
    rule_t r;
    r.idx        = idx;
    r.start_addr = lo;
    r.end_addr   = hi;
    return r;
  endfunction

  task automatic take_target_req(input int j);
    tgt_req_t got;
    tgt_rsp_t rsp;
    int       k;
    got = tgt_req_o[j];
    k   = j * `XBAR_NUM_INIT + int'(got.id[`XBAR_ID_W]);
    if (exp_req[k].size() == 0) begin
      abort_run($sformatf("Target %0d received a beat that was never sent to it", j));
    end else begin
      check_tgt_req(got, exp_req[k].pop_front(), $sformatf("target %0d request", j));
      arrival_src[j].push_back(got.id[`XBAR_ID_W]);
      rsp.id    = got.id;
      rsp.rdata = got.addr + RDATA_TAG;
      rsp.code  = RESP_OKAY;
      pend[j].push_back(rsp);
    end
  endtask

  task automatic take_init_rsp(input int i);
    if (exp_rsp[i].size() == 0) begin
      abort_run($sformatf("Initiator %0d got a response with nothing outstanding", i));
    end else begin
      check_init_rsp(init_rsp_o[i], exp_rsp[i].pop_front(), $sformatf("initiator %0d rsp", i));
    end
  endtask

  // Target models and response monitor sample at the rising edge and drive at the falling one
  always begin : target_model
    @(posedge clk_i);
    for (int j = 0; j < `XBAR_NUM_TARGET; j++) begin
      if (!reset_i && tgt_req_valid_o[j] && tgt_req_ready_i[j]) begin
        take_target_req(j);
      end
      if (tgt_rsp_valid_i[j] && tgt_rsp_ready_o[j]) begin
        rsp_taken[j] = 1'b1;
      end
    end
    for (int i = 0; i < `XBAR_NUM_INIT; i++) begin
      if (!reset_i && init_rsp_valid_o[i] && init_rsp_ready_i[i]) begin
        take_init_rsp(i);
      end
    end
    @(negedge clk_i);
    for (int j = 0; j < `XBAR_NUM_TARGET; j++) begin
      if (rsp_taken[j]) begin
        tgt_rsp_valid_i[j] = 1'b0;
        rsp_taken[j]       = 1'b0;
      end
      tgt_req_ready_i[j] = !hold_low[j] && ($urandom_range(3) != 0);
      if (!tgt_rsp_valid_i[j] && (pend[j].size() != 0)) begin
        if (rsp_wait[j] == 0) begin
          tgt_rsp_i[j]       = pend[j].pop_front();  // In request order
          tgt_rsp_valid_i[j] = 1'b1;
          rsp_wait[j]        = $urandom_range(3);
        end else begin
          rsp_wait[j] = rsp_wait[j] - 1;
        end
      end
    end
    for (int i = 0; i < `XBAR_NUM_INIT; i++) begin
      init_rsp_ready_i[i] = ($urandom_range(3) != 0);  // Response back-pressure
    end
  end

  // Starts and ends on a falling edge with dst a target index or ERR_DST
  task automatic send(input int i, input addr_t addr, input int dst);
    init_req_t req;
    tgt_req_t  exp;
    init_rsp_t rsp;
    req.addr  = addr;
    req.id    = next_id[i];
    req.write = 1'($urandom_range(1));
    req.wdata = $urandom;
    next_id[i]          = next_id[i] + 4'd1;
    init_req_i[i]       = req;
    init_req_valid_i[i] = 1'b1;
    do begin
      @(posedge clk_i);
    end while (!init_req_ready_o[i]);
    rsp.id = req.id;
    if (dst == ERR_DST) begin
      rsp.rdata = '0;
      rsp.code  = RESP_DECERR;
    end else begin
      exp.addr  = req.addr;
      exp.id    = {1'(i), req.id};  // Initiator index on top
      exp.write = req.write;
      exp.wdata = req.wdata;
      exp_req[dst * `XBAR_NUM_INIT + i].push_back(exp);
      rsp.rdata = req.addr + RDATA_TAG;
      rsp.code  = RESP_OKAY;
    end
    exp_rsp[i].push_back(rsp);
    @(negedge clk_i);
    if (dst != ERR_DST) begin
      if (!tgt_req_valid_o[dst]) begin
        abort_run($sformatf("Target %0d valid missing one cycle after the handshake", dst));
      end else begin
        check_tgt_req(tgt_req_o[dst], exp, "one-cycle target beat");
      end
    end
    init_req_valid_i[i] = 1'b0;
  endtask

  task automatic drain();
    logic busy;
    do begin
      @(negedge clk_i);
      busy = 1'b0;
      for (int k = 0; k < `XBAR_NUM_TARGET * `XBAR_NUM_INIT; k++) begin
        busy = busy || (exp_req[k].size() != 0);
      end
      for (int i = 0; i < `XBAR_NUM_INIT; i++) begin
        busy = busy || (exp_rsp[i].size() != 0);
      end
    end while (busy);
  endtask

  task automatic route_by_rules();
    send(0, 32'h0000_0100, 0);
    send(0, 32'h1000_0040, 1);
    send(1, 32'h0800_0010, 1);  // Also inside rule 0 where the later rule wins
    send(1, 32'h0fff_fffc, 0);
    send(0, 32'h1fff_fffc, 1);
    send(1, 32'h1000_0000, 1);
    drain();
  endtask

  task automatic decode_error_path();
    send(0, 32'h5000_0000, ERR_DST);
    send(0, 32'h2000_0000, ERR_DST);  // End address is exclusive
    drain();
    en_default_i[0]  = 1'b1;
    default_idx_i[0] = 1'b1;
    send(0, 32'h5000_0000, 1);
    drain();
    en_default_i[0]  = 1'b0;
  endtask

  task automatic arbitrate_two_initiators();
    arrival_src[0].delete();
    fork
      for (int n = 0; n < 4; n++) send(0, 32'h0000_1000 + 32'(n * 4), 0);
      for (int n = 0; n < 4; n++) send(1, 32'h0000_2000 + 32'(n * 4), 0);
    join
    drain();
    for (int n = 1; n < arrival_src[0].size(); n++) begin
      if (arrival_src[0][n] == arrival_src[0][n-1]) begin
        abort_run($sformatf("Target 0 granted initiator %0d twice in a row", arrival_src[0][n]));
      end
    end
  endtask

  task automatic stall_target();
    hold_low[0] = 1'b1;
    @(negedge clk_i);
    send(1, 32'h0000_0200, 0);  // Parks in the mux register
    fork
      send(1, 32'h0000_0204, 0);
      send(0, 32'h0000_0208, 0);
      begin
        repeat (6) begin
          @(posedge clk_i);
          if (init_req_ready_o != '0) begin
            abort_run("A beat was accepted while target 0 was held off");
          end else if (!tgt_req_valid_o[0]) begin
            abort_run("Target 0 lost its held request");
          end
        end
        @(negedge clk_i);
        hold_low[0] = 1'b0;
      end
    join
    drain();
  endtask

  task automatic keep_issue_order();
    fork
      begin
        send(0, 32'h0000_3000, 0);
        send(0, 32'h0000_3004, 0);
        send(0, 32'h1000_3000, 1);
        send(0, 32'h1000_3004, 1);
        send(0, 32'h6000_0000, ERR_DST);
        send(0, 32'h0000_3008, 0);
      end
      begin
        send(1, 32'h1000_4000, 1);
        send(1, 32'h0000_4000, 0);
      end
    join
    drain();
  endtask

  initial begin : main
    void'($urandom(59));
    reset_i          = 1'b1;
    init_req_i       = '0;
    init_req_valid_i = '0;
    init_rsp_ready_i = '1;
    en_default_i     = '0;
    default_idx_i    = '0;
    next_id          = '{default: '0};
    addr_map_i[0]    = build_rule(1'b0, 32'h0000_0000, 32'h1000_0000);
    addr_map_i[1]    = build_rule(1'b1, 32'h1000_0000, 32'h2000_0000);
    addr_map_i[2]    = build_rule(1'b1, 32'h0800_0000, 32'h0900_0000);
    repeat (RESET_CYCLES) @(posedge clk_i);
    @(negedge clk_i);
    reset_i = 1'b0;
    route_by_rules();
    decode_error_path();
    arbitrate_two_initiators();
    stall_target();
    keep_issue_order();
    $display("Simulation PASSED");
    $finish;
  end

endmodule

// File: verification/xbar_assert.sv
// Handshake and default-port checks, bound onto the crossbar top level from the testbench
`timescale 1ns/1ns
`include "xbar_consts.svh"

module xbar_assert (
  input logic                                      clk_i,
  input logic                                      reset_i,
  input xbar_pkg::init_req_t [`XBAR_NUM_INIT-1:0]  init_req_i,
  input logic [`XBAR_NUM_INIT-1:0]                 init_req_valid_i,
  input logic [`XBAR_NUM_INIT-1:0]                 init_req_ready_o,
  input xbar_pkg::init_rsp_t [`XBAR_NUM_INIT-1:0]  init_rsp_o,
  input logic [`XBAR_NUM_INIT-1:0]                 init_rsp_valid_o,
  input logic [`XBAR_NUM_INIT-1:0]                 init_rsp_ready_i,
  input xbar_pkg::tgt_req_t [`XBAR_NUM_TARGET-1:0] tgt_req_o,
  input logic [`XBAR_NUM_TARGET-1:0]               tgt_req_valid_o,
  input logic [`XBAR_NUM_TARGET-1:0]               tgt_req_ready_i,
  input xbar_pkg::tgt_rsp_t [`XBAR_NUM_TARGET-1:0] tgt_rsp_i,
  input logic [`XBAR_NUM_TARGET-1:0]               tgt_rsp_valid_i,
  input logic [`XBAR_NUM_TARGET-1:0]               tgt_rsp_ready_o,
  input logic [`XBAR_NUM_INIT-1:0]                 en_default_i,
  input xbar_pkg::tgt_idx_t [`XBAR_NUM_INIT-1:0]   default_idx_i
);

  for (genvar i = 0; i < `XBAR_NUM_INIT; i++) begin : gen_init
    a_init_req_hold: assert property (@(posedge clk_i) disable iff (reset_i)
      init_req_valid_i[i] && !init_req_ready_o[i] |=>
        init_req_valid_i[i] && $stable(init_req_i[i]))
      else $error("Initiator %0d request changed before ready", i);

    a_init_rsp_hold: assert property (@(posedge clk_i) disable iff (reset_i)
      init_rsp_valid_o[i] && !init_rsp_ready_i[i] |=>
        init_rsp_valid_o[i] && $stable(init_rsp_o[i]))
      else $error("Initiator %0d response changed before ready", i);

    // Decode inputs must not move under a pending beat
    a_default_hold: assert property (@(posedge clk_i) disable iff (reset_i)
      init_req_valid_i[i] && !init_req_ready_o[i] |=>
        $stable(en_default_i[i]) && $stable(default_idx_i[i]))
      else $error("Initiator %0d default port changed while a request was pending", i);
  end

  for (genvar j = 0; j < `XBAR_NUM_TARGET; j++) begin : gen_tgt
    a_tgt_req_hold: assert property (@(posedge clk_i) disable iff (reset_i)
      tgt_req_valid_o[j] && !tgt_req_ready_i[j] |=>
        tgt_req_valid_o[j] && $stable(tgt_req_o[j]))
      else $error("Target %0d request changed before ready", j);

    a_tgt_rsp_hold: assert property (@(posedge clk_i) disable iff (reset_i)
      tgt_rsp_valid_i[j] && !tgt_rsp_ready_o[j] |=>
        tgt_rsp_valid_i[j] && $stable(tgt_rsp_i[j]))
      else $error("Target %0d response changed before ready", j);
  end

endmodule

// File: logic/xbar_top.sv
// Crossbar top level; one demux and error responder per initiator, one mux per target
`timescale 1ns/1ns
`include "xbar_consts.svh"

module xbar_top (
  input  logic                                        clk_i,
  input  logic                                        reset_i,
  input  xbar_pkg::init_req_t [`XBAR_NUM_INIT-1:0]    init_req_i,
  input  logic [`XBAR_NUM_INIT-1:0]                   init_req_valid_i,
  output logic [`XBAR_NUM_INIT-1:0]                   init_req_ready_o,
  output xbar_pkg::init_rsp_t [`XBAR_NUM_INIT-1:0]    init_rsp_o,
  output logic [`XBAR_NUM_INIT-1:0]                   init_rsp_valid_o,
  input  logic [`XBAR_NUM_INIT-1:0]                   init_rsp_ready_i,
  output xbar_pkg::tgt_req_t [`XBAR_NUM_TARGET-1:0]   tgt_req_o,
  output logic [`XBAR_NUM_TARGET-1:0]                 tgt_req_valid_o,
  input  logic [`XBAR_NUM_TARGET-1:0]                 tgt_req_ready_i,
  input  xbar_pkg::tgt_rsp_t [`XBAR_NUM_TARGET-1:0]   tgt_rsp_i,
  input  logic [`XBAR_NUM_TARGET-1:0]                 tgt_rsp_valid_i,
  output logic [`XBAR_NUM_TARGET-1:0]                 tgt_rsp_ready_o,
  input  xbar_pkg::rule_t [`XBAR_NUM_RULES-1:0]       addr_map_i,  // Shared by all initiators
  input  logic [`XBAR_NUM_INIT-1:0]                   en_default_i,
  input  xbar_pkg::tgt_idx_t [`XBAR_NUM_INIT-1:0]     default_idx_i
);

  import xbar_pkg::*;

  // Demux side, indexed [initiator][lane]
  init_req_t [`XBAR_NUM_INIT-1:0][`XBAR_NUM_LANES-1:0] dmx_req;
  logic      [`XBAR_NUM_INIT-1:0][`XBAR_NUM_LANES-1:0] dmx_valid;
  logic      [`XBAR_NUM_INIT-1:0][`XBAR_NUM_LANES-1:0] dmx_ready;
  init_rsp_t [`XBAR_NUM_INIT-1:0][`XBAR_NUM_LANES-1:0] dmx_rsp;
  logic      [`XBAR_NUM_INIT-1:0][`XBAR_NUM_LANES-1:0] dmx_rsp_valid;
  logic      [`XBAR_NUM_INIT-1:0][`XBAR_NUM_LANES-1:0] dmx_rsp_ready;

  // Mux side, indexed [target][initiator]
  init_req_t [`XBAR_NUM_TARGET-1:0][`XBAR_NUM_INIT-1:0] mux_req;
  logic      [`XBAR_NUM_TARGET-1:0][`XBAR_NUM_INIT-1:0] mux_valid;
  logic      [`XBAR_NUM_TARGET-1:0][`XBAR_NUM_INIT-1:0] mux_ready;
  init_rsp_t [`XBAR_NUM_TARGET-1:0][`XBAR_NUM_INIT-1:0] mux_rsp;
  logic      [`XBAR_NUM_TARGET-1:0][`XBAR_NUM_INIT-1:0] mux_rsp_valid;
  logic      [`XBAR_NUM_TARGET-1:0][`XBAR_NUM_INIT-1:0] mux_rsp_ready;

  for (genvar i = 0; i < `XBAR_NUM_INIT; i++) begin : gen_init
    xbar_demux u_xbar_demux (
      .clk_i            (clk_i),
      .reset_i          (reset_i),
      .init_req_i       (init_req_i[i]),
      .init_req_valid_i (init_req_valid_i[i]),
      .init_req_ready_o (init_req_ready_o[i]),
      .init_rsp_o       (init_rsp_o[i]),
      .init_rsp_valid_o (init_rsp_valid_o[i]),
      .init_rsp_ready_i (init_rsp_ready_i[i]),
      .addr_map_i       (addr_map_i),
      .en_default_i     (en_default_i[i]),
      .default_idx_i    (default_idx_i[i]),
      .lane_req_o       (dmx_req[i]),
      .lane_valid_o     (dmx_valid[i]),
      .lane_ready_i     (dmx_ready[i]),
      .lane_rsp_i       (dmx_rsp[i]),
      .lane_rsp_valid_i (dmx_rsp_valid[i]),
      .lane_rsp_ready_o (dmx_rsp_ready[i])
    );

    // Last lane ends in the error responder
    err_target u_err_target (
      .clk_i       (clk_i),
      .reset_i     (reset_i),
      .req_i       (dmx_req[i][`XBAR_NUM_TARGET]),
      .req_valid_i (dmx_valid[i][`XBAR_NUM_TARGET]),
      .req_ready_o (dmx_ready[i][`XBAR_NUM_TARGET]),
      .rsp_o       (dmx_rsp[i][`XBAR_NUM_TARGET]),
      .rsp_valid_o (dmx_rsp_valid[i][`XBAR_NUM_TARGET]),
      .rsp_ready_i (dmx_rsp_ready[i][`XBAR_NUM_TARGET])
    );

    for (genvar j = 0; j < `XBAR_NUM_TARGET; j++) begin : gen_cross
      assign mux_req[j][i]       = dmx_req[i][j];
      assign mux_valid[j][i]     = dmx_valid[i][j];
      assign dmx_ready[i][j]     = mux_ready[j][i];
      assign dmx_rsp[i][j]       = mux_rsp[j][i];
      assign dmx_rsp_valid[i][j] = mux_rsp_valid[j][i];
      assign mux_rsp_ready[j][i] = dmx_rsp_ready[i][j];
    end
  end

  for (genvar j = 0; j < `XBAR_NUM_TARGET; j++) begin : gen_tgt
    xbar_mux u_xbar_mux (
      .clk_i            (clk_i),
      .reset_i          (reset_i),
      .init_req_i       (mux_req[j]),
      .init_valid_i     (mux_valid[j]),
      .init_ready_o     (mux_ready[j]),
      .init_rsp_o       (mux_rsp[j]),
      .init_rsp_valid_o (mux_rsp_valid[j]),
      .init_rsp_ready_i (mux_rsp_ready[j]),
      .tgt_req_o        (tgt_req_o[j]),
      .tgt_req_valid_o  (tgt_req_valid_o[j]),
      .tgt_req_ready_i  (tgt_req_ready_i[j]),
      .tgt_rsp_i        (tgt_rsp_i[j]),
      .tgt_rsp_valid_i  (tgt_rsp_valid_i[j]),
      .tgt_rsp_ready_o  (tgt_rsp_ready_o[j])
    );
  end

endmodule

// File: logic/xbar_mux.sv
// Per-target round-robin mux; tags IDs with the initiator, registers one beat, routes responses
`timescale 1ns/1ns
`include "xbar_consts.svh"

module xbar_mux (
  input  logic                                      clk_i,
  input  logic                                      reset_i,
  input  xbar_pkg::init_req_t [`XBAR_NUM_INIT-1:0]  init_req_i,
  input  logic [`XBAR_NUM_INIT-1:0]                 init_valid_i,
  output logic [`XBAR_NUM_INIT-1:0]                 init_ready_o,
  output xbar_pkg::init_rsp_t [`XBAR_NUM_INIT-1:0]  init_rsp_o,
  output logic [`XBAR_NUM_INIT-1:0]                 init_rsp_valid_o,
  input  logic [`XBAR_NUM_INIT-1:0]                 init_rsp_ready_i,
  output xbar_pkg::tgt_req_t                        tgt_req_o,
  output logic                                      tgt_req_valid_o,
  input  logic                                      tgt_req_ready_i,
  input  xbar_pkg::tgt_rsp_t                        tgt_rsp_i,
  input  logic                                      tgt_rsp_valid_i,
  output logic                                      tgt_rsp_ready_o
);

  import xbar_pkg::*;

  logic      prio;        // Initiator that wins a tie
  logic      gnt_idx;
  logic      gnt_valid;
  logic      load_en;
  logic      rsp_dst;     // Initiator named by the response ID
  init_req_t gnt_req;
  tgt_req_t  req_q;
  logic      req_valid_q;

  // Two initiators, so round robin is a single priority bit
  always_comb begin
    gnt_idx = prio;
    if (!init_valid_i[prio]) begin
      gnt_idx = !prio;
    end
  end

  assign gnt_valid = |init_valid_i;
  assign gnt_req   = init_req_i[gnt_idx];

  // Register is free when empty or draining this cycle
  assign load_en = !req_valid_q || tgt_req_ready_i;

  always_comb begin
    for (int i = 0; i < `XBAR_NUM_INIT; i++) begin
      init_ready_o[i] = load_en && gnt_valid && (gnt_idx == 1'(i));
    end
  end

  always_ff @(posedge clk_i) begin
    if (load_en && gnt_valid) begin
      req_q.addr  <= gnt_req.addr;
      req_q.id    <= tgt_id_t'({gnt_idx, gnt_req.id});  // Prefix with source initiator
      req_q.write <= gnt_req.write;
      req_q.wdata <= gnt_req.wdata;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      req_valid_q <= 1'b0;
      prio        <= 1'b0;
    end else if (load_en) begin
      req_valid_q <= gnt_valid;
      if (gnt_valid) begin
        prio <= !gnt_idx;     // Other side goes first next time
      end
    end
  end

  assign tgt_req_o       = req_q;
  assign tgt_req_valid_o = req_valid_q;

  // Response path is purely combinational
  assign rsp_dst = tgt_rsp_i.id[`XBAR_ID_W];

  always_comb begin
    for (int i = 0; i < `XBAR_NUM_INIT; i++) begin
      init_rsp_o[i].id    = tgt_rsp_i.id[`XBAR_ID_W-1:0];
      init_rsp_o[i].rdata = tgt_rsp_i.rdata;
      init_rsp_o[i].code  = tgt_rsp_i.code;
      init_rsp_valid_o[i] = tgt_rsp_valid_i && (rsp_dst == 1'(i));
    end
  end

  assign tgt_rsp_ready_o = init_rsp_ready_i[rsp_dst];

endmodule

// File: logic/err_target.sv
// Decode-error responder; absorbs unmapped requests and answers each with DECERR
`timescale 1ns/1ns
`include "xbar_consts.svh"

module err_target (
  input  logic                clk_i,
  input  logic                reset_i,
  input  xbar_pkg::init_req_t req_i,
  input  logic                req_valid_i,
  output logic                req_ready_o,
  output xbar_pkg::init_rsp_t rsp_o,
  output logic                rsp_valid_o,
  input  logic                rsp_ready_i
);

  import xbar_pkg::*;

  init_id_t   id_mem [2];   // Two pending IDs
  logic       wr_ptr;
  logic       rd_ptr;
  logic [1:0] count;
  logic       push;
  logic       pop;

  assign req_ready_o = (count != 2'd2);
  assign rsp_valid_o = (count != 2'd0);

  assign push = req_valid_i && req_ready_o;
  assign pop  = rsp_valid_o && rsp_ready_i;

  always_comb begin
    rsp_o       = '0;
    rsp_o.id    = id_mem[rd_ptr];
    rsp_o.code  = RESP_DECERR;   // rdata stays zero
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      id_mem[wr_ptr] <= req_i.id;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wr_ptr <= 1'b0;
      rd_ptr <= 1'b0;
      count  <= 2'd0;
    end else begin
      if (push) begin
        wr_ptr <= !wr_ptr;
      end
      if (pop) begin
        rd_ptr <= !rd_ptr;
      end
      case ({push, pop})
        2'b10:   count <= count + 2'd1;
        2'b01:   count <= count - 2'd1;
        default: count <= count;
      endcase
    end
  end

endmodule

// File: logic/xbar_demux.sv
// Per-initiator request steering onto target lanes or the error lane, with in-order responses
`timescale 1ns/1ns
`include "xbar_consts.svh"

module xbar_demux (
  input  logic                                       clk_i,
  input  logic                                       reset_i,
  input  xbar_pkg::init_req_t                        init_req_i,
  input  logic                                       init_req_valid_i,
  output logic                                       init_req_ready_o,
  output xbar_pkg::init_rsp_t                        init_rsp_o,
  output logic                                       init_rsp_valid_o,
  input  logic                                       init_rsp_ready_i,
  input  xbar_pkg::rule_t [`XBAR_NUM_RULES-1:0]      addr_map_i,
  input  logic                                       en_default_i,
  input  xbar_pkg::tgt_idx_t                         default_idx_i,
  output xbar_pkg::init_req_t [`XBAR_NUM_LANES-1:0]  lane_req_o,
  output logic [`XBAR_NUM_LANES-1:0]                 lane_valid_o,
  input  logic [`XBAR_NUM_LANES-1:0]                 lane_ready_i,
  input  xbar_pkg::init_rsp_t [`XBAR_NUM_LANES-1:0]  lane_rsp_i,
  input  logic [`XBAR_NUM_LANES-1:0]                 lane_rsp_valid_i,
  output logic [`XBAR_NUM_LANES-1:0]                 lane_rsp_ready_o
);

  import xbar_pkg::*;

  localparam int cnt_w = $clog2(`XBAR_MAX_TRANS + 1);

  tgt_idx_t           dec_idx;
  logic               dec_error;
  sel_t               sel;
  sel_t               last_sel;     // Destination of the outstanding requests
  logic [cnt_w-1:0]   out_cnt;
  logic               allow;
  logic               lane_rdy;
  logic               req_fire;
  logic               rsp_fire;

  addr_decode u_addr_decode (
    .addr_i        (init_req_i.addr),
    .addr_map_i    (addr_map_i),
    .en_default_i  (en_default_i),
    .default_idx_i (default_idx_i),
    .idx_o         (dec_idx),
    .dec_error_o   (dec_error)
  );

  assign sel = dec_error ? sel_t'(`XBAR_NUM_TARGET) : sel_t'(dec_idx);

  // New destination only once everything has drained, never past the limit
  assign allow = (out_cnt == '0) ||
                 ((sel == last_sel) && (out_cnt != cnt_w'(`XBAR_MAX_TRANS)));

  always_comb begin
    lane_rdy = 1'b0;
    for (int k = 0; k < `XBAR_NUM_LANES; k++) begin
      lane_req_o[k]   = init_req_i;  // Payload fans out, valid picks the lane
      lane_valid_o[k] = init_req_valid_i && allow && (sel == sel_t'(k));
      if (sel == sel_t'(k)) begin
        lane_rdy = lane_ready_i[k];
      end
    end
  end

  assign init_req_ready_o = allow && lane_rdy;

  // Responses come back on the lane that holds the outstanding requests
  always_comb begin
    init_rsp_o       = '0;
    init_rsp_valid_o = 1'b0;
    for (int k = 0; k < `XBAR_NUM_LANES; k++) begin
      lane_rsp_ready_o[k] = init_rsp_ready_i && (last_sel == sel_t'(k));
      if (last_sel == sel_t'(k)) begin
        init_rsp_o       = lane_rsp_i[k];
        init_rsp_valid_o = lane_rsp_valid_i[k];
      end
    end
  end

  assign req_fire = init_req_valid_i && init_req_ready_o;
  assign rsp_fire = init_rsp_valid_o && init_rsp_ready_i;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      last_sel <= '0;
      out_cnt  <= '0;
    end else begin
      if (req_fire) begin
        last_sel <= sel;
      end
      if (req_fire && !rsp_fire) begin
        out_cnt <= out_cnt + 1'b1;
      end else if (!req_fire && rsp_fire) begin
        out_cnt <= out_cnt - 1'b1;
      end
    end
  end

endmodule

// File: logic/addr_decode.sv
// Address decoder for one initiator; maps an address onto a target index via the rule map
`timescale 1ns/1ns
`include "xbar_consts.svh"

module addr_decode (
  input  xbar_pkg::addr_t                        addr_i,
  input  xbar_pkg::rule_t [`XBAR_NUM_RULES-1:0]  addr_map_i,
  input  logic                                   en_default_i,
  input  xbar_pkg::tgt_idx_t                     default_idx_i,
  output xbar_pkg::tgt_idx_t                     idx_o,
  output logic                                   dec_error_o
);

  import xbar_pkg::*;

  tgt_idx_t match_idx;
  logic     match;

  // Walk all rules, a later hit overrides an earlier one
  always_comb begin
    match     = 1'b0;
    match_idx = '0;
    for (int r = 0; r < `XBAR_NUM_RULES; r++) begin
      if ((addr_i >= addr_map_i[r].start_addr) && (addr_i < addr_map_i[r].end_addr)) begin
        match     = 1'b1;
        match_idx = addr_map_i[r].idx;
      end
    end
  end

  always_comb begin
    idx_o       = match_idx;
    dec_error_o = 1'b0;
    if (!match) begin
      idx_o       = default_idx_i;  // Only meaningful when the default is on
      dec_error_o = !en_default_i;
    end
  end

endmodule

// File: logic/xbar_pkg.sv
// Shared crossbar types: payload vectors, channel structs and address rules
`include "xbar_consts.svh"

package xbar_pkg;

  typedef logic [`XBAR_ADDR_W-1:0] addr_t;
  typedef logic [`XBAR_DATA_W-1:0] data_t;
  typedef logic [`XBAR_ID_W-1:0]   init_id_t;
  typedef logic [`XBAR_ID_W:0]     tgt_id_t;   // Top bit names the initiator
  typedef logic [$clog2(`XBAR_NUM_TARGET)-1:0] tgt_idx_t;
  typedef logic [1:0]              sel_t;      // Value 2 selects the error responder
  typedef logic [1:0]              resp_code_t;

  localparam resp_code_t RESP_OKAY   = 2'b00;
  localparam resp_code_t RESP_DECERR = 2'b11;

  typedef struct packed {
    addr_t    addr;
    init_id_t id;
    logic     write;
    data_t    wdata;
  } init_req_t;

  typedef struct packed {
    addr_t   addr;
    tgt_id_t id;
    logic    write;
    data_t   wdata;
  } tgt_req_t;

  typedef struct packed {
    init_id_t   id;
    data_t      rdata;
    resp_code_t code;
  } init_rsp_t;

  typedef struct packed {
    tgt_id_t    id;
    data_t      rdata;
    resp_code_t code;
  } tgt_rsp_t;

  // Match when start_addr <= addr < end_addr
  typedef struct packed {
    tgt_idx_t idx;
    addr_t    start_addr;
    addr_t    end_addr;
  } rule_t;

endpackage

// File: include/xbar_consts.svh
// Crossbar size and width constants, included by the package and every RTL file
`ifndef XBAR_CONSTS_SVH
`define XBAR_CONSTS_SVH

// Port counts
`define XBAR_NUM_INIT   2
`define XBAR_NUM_TARGET 2
`define XBAR_NUM_RULES  3

// Each demux also drives a lane to its decode-error responder
`define XBAR_NUM_LANES  (`XBAR_NUM_TARGET + 1)

// Payload widths
`define XBAR_ADDR_W     32
`define XBAR_DATA_W     32
`define XBAR_ID_W       4   // Initiator-side ID, target side adds one bit

// Outstanding requests per initiator
`define XBAR_MAX_TRANS  7

`endif
